//--- design/arenaPkg.sv
// arena types (coordinates, heading, trig, colour, scene) and palette constants

package arenaPkg;

    // ----------------------------------------
    // basic scalar types
    // ----------------------------------------

    // screen coordinate, covers 640x480 and smaller
    typedef logic [9:0] coord_t;

    // 16 steps of 22.5 degrees
    typedef logic [3:0] heading_t;

    // Q1.7, so +127 means just under 1.0
    typedef logic signed [7:0] trig_t;

    // ----------------------------------------
    // grouped types
    // ----------------------------------------

    typedef struct packed {
        coord_t x;
        coord_t y;
    } point_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    // one complete scene as seen by the mapper
    typedef struct packed {
        point_t   tank1;
        point_t   tank2;
        point_t   bullet;
        heading_t heading;
        logic     bulletActive;
        // shared half width of every box
        coord_t   halfSize;
    } scene_t;

    // ----------------------------------------
    // palette
    // ----------------------------------------

    localparam rgb_t tank1Color  = '{red: 8'hff, green: 8'hbb, blue: 8'h00};
    localparam rgb_t tank2Color  = '{red: 8'hff, green: 8'h00, blue: 8'h00};
    localparam rgb_t bulletColor = '{red: 8'h32, green: 8'hdd, blue: 8'hde};
    localparam rgb_t floorColor  = '{red: 8'h55, green: 8'h55, blue: 8'h55};
    // outside the visible window
    localparam rgb_t blankColor  = '{red: 8'h00, green: 8'h00, blue: 8'h00};

endpackage

//--- design/vgaTiming.sv
// VGA-style timing generator: column/row counters, display enable, syncs, frame start

module vgaTiming import arenaPkg::*;
#(
    parameter int hVisible = 640,
    parameter int hFront   = 16,
    parameter int hSyncLen = 96,
    parameter int hBack    = 48,
    parameter int vVisible = 480,
    parameter int vFront   = 10,
    parameter int vSyncLen = 2,
    parameter int vBack    = 33
)
(
    input  logic   clk,
    input  logic   rstN,
    output point_t drawPos,
    output logic   displayOn,
    output logic   frameStart,
    output logic   hSyncRaw,
    output logic   vSyncRaw
);

    // ----------------------------------------
    // derived frame geometry
    // ----------------------------------------

    // last column and last row of the full frame
    localparam coord_t hLast = coord_t'(hVisible + hFront + hSyncLen + hBack - 1);
    localparam coord_t vLast = coord_t'(vVisible + vFront + vSyncLen + vBack - 1);

    // sync window starts after visible area and front porch
    localparam coord_t hSyncFirst = coord_t'(hVisible + hFront);
    localparam coord_t hSyncStop  = coord_t'(hVisible + hFront + hSyncLen);
    localparam coord_t vSyncFirst = coord_t'(vVisible + vFront);
    localparam coord_t vSyncStop  = coord_t'(vVisible + vFront + vSyncLen);

    localparam coord_t hVisEnd = coord_t'(hVisible);
    localparam coord_t vVisEnd = coord_t'(vVisible);

    coord_t col;
    coord_t row;

    // ----------------------------------------
    // counters
    // ----------------------------------------

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            col <= '0;
            row <= '0;
        end
        else if (col == hLast)
        begin
            // end of line, step to next row
            col <= '0;
            if (row == vLast)
                row <= '0;
            else
                row <= row + 1'b1;
        end
        else
        begin
            col <= col + 1'b1;
        end
    end

    // ----------------------------------------
    // decoded levels, all combinational
    // ----------------------------------------

    assign drawPos    = '{x: col, y: row};
    assign displayOn  = (col < hVisEnd) && (row < vVisEnd);
    // single cycle at top left corner
    assign frameStart = (col == '0) && (row == '0);

    // active low inside the sync interval
    assign hSyncRaw = !((col >= hSyncFirst) && (col < hSyncStop));
    assign vSyncRaw = !((row >= vSyncFirst) && (row < vSyncStop));

endmodule

//--- design/sinCosRom.sv
// sine/cosine lookup for the tank-2 heading, Q1.7 signed values

module sinCosRom import arenaPkg::*;
(
    input  heading_t heading,
    output trig_t    sinVal,
    output trig_t    cosVal
);

    // quarter turn in table steps
    localparam heading_t quarterTurn = 4'd4;

    heading_t cosIndex;

    // one period of sine, 16 samples
    function automatic trig_t sineOf(input heading_t idx);
        trig_t val;
        case (idx)
            4'd0:    val = 8'sd0;
            4'd1:    val = 8'sd49;
            4'd2:    val = 8'sd90;
            4'd3:    val = 8'sd117;
            4'd4:    val = 8'sd127;
            4'd5:    val = 8'sd117;
            4'd6:    val = 8'sd90;
            4'd7:    val = 8'sd49;
            4'd8:    val = 8'sd0;
            4'd9:    val = -8'sd49;
            4'd10:   val = -8'sd90;
            4'd11:   val = -8'sd117;
            4'd12:   val = -8'sd127;
            4'd13:   val = -8'sd117;
            4'd14:   val = -8'sd90;
            default: val = -8'sd49;
        endcase
        return val;
    endfunction

    // 4 bit add wraps modulo 16 on its own
    assign cosIndex = heading + quarterTurn;

    // ----------------------------------------
    // table reads
    // ----------------------------------------

    // combinational so rotation sees heading in same cycle
    assign sinVal = sineOf(heading);
    assign cosVal = sineOf(cosIndex);

endmodule

//--- design/rotatePoint.sv
// fixed-point rotation of the draw position about the tank-2 centre

module rotatePoint import arenaPkg::*;
(
    input  point_t drawPos,
    input  point_t centre,
    input  trig_t  sinVal,
    input  trig_t  cosVal,
    output point_t rotPos
);

    // offsets, one extra bit for sign
    logic signed [10:0] dx;
    logic signed [10:0] dy;

    // 11 bit x 8 bit products
    logic signed [18:0] prodXCos;
    logic signed [18:0] prodYSin;
    logic signed [18:0] prodXSin;
    logic signed [18:0] prodYCos;

    // rotated offsets before and after Q1.7 scaling
    logic signed [19:0] sumX;
    logic signed [19:0] sumY;
    logic signed [19:0] scaledX;
    logic signed [19:0] scaledY;

    // ----------------------------------------
    // offsets from centre
    // ----------------------------------------

    assign dx = $signed({1'b0, drawPos.x}) - $signed({1'b0, centre.x});
    assign dy = $signed({1'b0, drawPos.y}) - $signed({1'b0, centre.y});

    // ----------------------------------------
    // rotate and scale
    // ----------------------------------------

    assign prodXCos = dx * cosVal;
    assign prodYSin = dy * sinVal;
    assign prodXSin = dx * sinVal;
    assign prodYCos = dy * cosVal;

    assign sumX = prodXCos - prodYSin;
    assign sumY = prodXSin + prodYCos;

    // arithmetic shift gives floor of divide by 128
    assign scaledX = sumX >>> 7;
    assign scaledY = sumY >>> 7;

    // back into screen space, wraps at 10 bits
    assign rotPos.x = centre.x + scaledX[9:0];
    assign rotPos.y = centre.y + scaledY[9:0];

endmodule

//--- design/sceneRegs.sv
// double-buffered scene registers, pending filled by load, active committed at frame start

module sceneRegs import arenaPkg::*;
(
    input  logic   clk,
    input  logic   rstN,
    input  logic   load,
    input  scene_t update,
    input  logic   frameStart,
    output scene_t active
);

    // ----------------------------------------
    // pending buffer
    // ----------------------------------------

    // written from outside, last load before frame start wins
    scene_t pending;

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            pending <= '0;
        end
        else if (load)
        begin
            pending <= update;
        end
    end

    // ----------------------------------------
    // active buffer
    // ----------------------------------------

    // only promoted at frame start so a frame never mixes scenes;
    // a load in the same cycle lands in pending and waits one frame
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            active <= '0;
        end
        else if (frameStart)
        begin
            active <= pending;
        end
    end

endmodule

//--- design/colorMapper.sv
// colour mapper: box tests, fixed priority, blanking and registered RGB output

module colorMapper import arenaPkg::*;
(
    input  logic   clk,
    input  logic   rstN,
    input  point_t drawPos,
    input  point_t rotPos,
    input  logic   displayOn,
    input  scene_t scene,
    output rgb_t   pixel
);

    logic inTank1;
    logic inTank2;
    logic inBullet;
    rgb_t nextColor;

    // square box around centre, unsigned 10 bit bounds
    function automatic logic inBox(input point_t p, input point_t c, input coord_t half);
        coord_t loX;
        coord_t hiX;
        coord_t loY;
        coord_t hiY;
        loX = c.x - half;
        hiX = c.x + half;
        loY = c.y - half;
        hiY = c.y + half;
        return (p.x >= loX) && (p.x <= hiX) && (p.y >= loY) && (p.y <= hiY);
    endfunction

    // ----------------------------------------
    // box tests
    // ----------------------------------------

    assign inTank1  = inBox(drawPos, scene.tank1, scene.halfSize);
    // tank 2 tested in rotated space
    assign inTank2  = inBox(rotPos, scene.tank2, scene.halfSize);
    assign inBullet = scene.bulletActive && inBox(drawPos, scene.bullet, scene.halfSize);

    // ----------------------------------------
    // priority select
    // ----------------------------------------

    always_comb
    begin
        if (!displayOn)
            nextColor = blankColor;
        else if (inTank1)
            nextColor = tank1Color;
        else if (inTank2)
            nextColor = tank2Color;
        else if (inBullet)
            nextColor = bulletColor;
        else
            nextColor = floorColor;
    end

    // one cycle behind the counters
    always_ff @(posedge clk)
    begin
        if (!rstN)
            pixel <= blankColor;
        else
            pixel <= nextColor;
    end

endmodule

//--- design/arenaTop.sv
// arena renderer top: timing, scene registers, trig table, rotation, mapper, sync delay

module arenaTop import arenaPkg::*;
#(
    parameter int hVisible = 640,
    parameter int hFront   = 16,
    parameter int hSyncLen = 96,
    parameter int hBack    = 48,
    parameter int vVisible = 480,
    parameter int vFront   = 10,
    parameter int vSyncLen = 2,
    parameter int vBack    = 33
)
(
    input  logic   clk,
    input  logic   rstN,
    input  logic   load,
    input  scene_t update,
    output rgb_t   pixel,
    output logic   hSync,
    output logic   vSync
);

    point_t drawPos;
    point_t rotPos;
    logic   displayOn;
    logic   frameStart;
    logic   hSyncRaw;
    logic   vSyncRaw;
    scene_t active;
    trig_t  sinVal;
    trig_t  cosVal;

    // ----------------------------------------
    // pipeline blocks
    // ----------------------------------------

    vgaTiming #(
        .hVisible (hVisible),
        .hFront   (hFront),
        .hSyncLen (hSyncLen),
        .hBack    (hBack),
        .vVisible (vVisible),
        .vFront   (vFront),
        .vSyncLen (vSyncLen),
        .vBack    (vBack)
    ) timingGen (
        .clk        (clk),
        .rstN       (rstN),
        .drawPos    (drawPos),
        .displayOn  (displayOn),
        .frameStart (frameStart),
        .hSyncRaw   (hSyncRaw),
        .vSyncRaw   (vSyncRaw)
    );

    sceneRegs sceneBank (
        .clk        (clk),
        .rstN       (rstN),
        .load       (load),
        .update     (update),
        .frameStart (frameStart),
        .active     (active)
    );

    // trig for current tank 2 heading
    sinCosRom trigTable (
        .heading (active.heading),
        .sinVal  (sinVal),
        .cosVal  (cosVal)
    );

    rotatePoint rotator (
        .drawPos (drawPos),
        .centre  (active.tank2),
        .sinVal  (sinVal),
        .cosVal  (cosVal),
        .rotPos  (rotPos)
    );

    colorMapper mapper (
        .clk       (clk),
        .rstN      (rstN),
        .drawPos   (drawPos),
        .rotPos    (rotPos),
        .displayOn (displayOn),
        .scene     (active),
        .pixel     (pixel)
    );

    // ----------------------------------------
    // sync alignment
    // ----------------------------------------

    // match the registered colour, idle high
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            hSync <= 1'b1;
            vSync <= 1'b1;
        end
        else
        begin
            hSync <= hSyncRaw;
            vSync <= vSyncRaw;
        end
    end

endmodule

//--- verification/tbArena.sv
// testbench for the arena renderer: clock, reset, reference model, directed tests, timeout

module tbArena import arenaPkg::*;
();

    // ----------------------------------------
    // small screen used by every test
    // ----------------------------------------

    localparam int hVisible   = 32;
    localparam int hFront     = 2;
    localparam int hSyncLen   = 4;
    localparam int hBack      = 2;
    localparam int vVisible   = 24;
    localparam int vFront     = 1;
    localparam int vSyncLen   = 2;
    localparam int vBack      = 1;
    localparam int lineLen    = hVisible + hFront + hSyncLen + hBack;
    localparam int frameLines = vVisible + vFront + vSyncLen + vBack;
    localparam int frameLen   = lineLen * frameLines;
    localparam int hSyncFirst = hVisible + hFront;
    localparam int vSyncFirst = vVisible + vFront;

    // about two frames per loaded scene, see the test list below
    localparam int testFrames    = 23;
    localparam int timeoutCycles = (testFrames + 2) * frameLen;

    logic   clk;
    logic   rstN;
    logic   load;
    scene_t update;
    rgb_t   pixel;
    logic   hSync;
    logic   vSync;

    int seed = 95241;
    int cycleCount = 0;

    // Q1.7 sine samples, 22.5 degree steps
    int sineTable [16] = '{0, 49, 90, 117, 127, 117, 90, 49,
                           0, -49, -90, -117, -127, -117, -90, -49};

    // DUT counter copy and the position shown at the outputs
    int mCol = 0;
    int mRow = 0;
    int outCol = 0;
    int outRow = 0;
    bit outValid = 1'b0;

    arenaTop #(
        .hVisible (hVisible),
        .hFront   (hFront),
        .hSyncLen (hSyncLen),
        .hBack    (hBack),
        .vVisible (vVisible),
        .vFront   (vFront),
        .vSyncLen (vSyncLen),
        .vBack    (vBack)
    ) u_dut (
        .clk    (clk),
        .rstN   (rstN),
        .load   (load),
        .update (update),
        .pixel  (pixel),
        .hSync  (hSync),
        .vSync  (vSync)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ----------------------------------------
    // position tracking and timeout
    // ----------------------------------------

    always @(posedge clk)
    begin
        if (!rstN)
        begin
            mCol = 0;
            mRow = 0;
            outValid = 1'b0;
        end
        else
        begin
            // outputs registered from the counter state before this edge
            outCol = mCol;
            outRow = mRow;
            outValid = 1'b1;
            if (mCol == lineLen - 1)
            begin
                mCol = 0;
                mRow = (mRow == frameLines - 1) ? 0 : mRow + 1;
            end
            else
            begin
                mCol = mCol + 1;
            end
        end
    end

    always @(posedge clk)
    begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= timeoutCycles)
        begin
            $display("Timeout: the tests did not finish within %0d cycles", timeoutCycles);
            abortRun;
        end
    end

    task automatic abortRun;
        $display("Something failed");
        $fatal(1);
    endtask

    // ----------------------------------------
    // reference model
    // ----------------------------------------

    // floor of v / d for d > 0
    function automatic int floorDiv(input int v, input int d);
        if (v >= 0)
            return v / d;
        return -((-v + d - 1) / d);
    endfunction

    // bounds wrap at 10 bits
    function automatic bit inBoxRef(input int px, input int py, input int cx, input int cy,
                                    input int half);
        int loX;
        int hiX;
        int loY;
        int hiY;
        loX = (cx - half) & 1023;
        hiX = (cx + half) & 1023;
        loY = (cy - half) & 1023;
        hiY = (cy + half) & 1023;
        return (px >= loX) && (px <= hiX) && (py >= loY) && (py <= hiY);
    endfunction

    function automatic rgb_t refColor(input int col, input int row, input scene_t s);
        int head;
        int sinT;
        int cosT;
        int cx;
        int cy;
        int dx;
        int dy;
        int rx;
        int ry;
        int half;
        head = s.heading;
        half = s.halfSize;
        cx = s.tank2.x;
        cy = s.tank2.y;
        if (col >= hVisible || row >= vVisible)
            return blankColor;
        sinT = sineTable[head];
        // cosine is a quarter turn ahead
        cosT = sineTable[(head + 4) % 16];
        dx = col - cx;
        dy = row - cy;
        rx = (cx + floorDiv(dx * cosT - dy * sinT, 128)) & 1023;
        ry = (cy + floorDiv(dx * sinT + dy * cosT, 128)) & 1023;
        if (inBoxRef(col, row, s.tank1.x, s.tank1.y, half))
            return tank1Color;
        if (inBoxRef(rx, ry, cx, cy, half))
            return tank2Color;
        if (s.bulletActive && inBoxRef(col, row, s.bullet.x, s.bullet.y, half))
            return bulletColor;
        return floorColor;
    endfunction

    function automatic scene_t makeScene(input int t1x, input int t1y, input int t2x,
                                         input int t2y, input int bx, input int by,
                                         input int head, input bit bulletOn, input int half);
        scene_t s;
        s.tank1.x      = coord_t'(t1x);
        s.tank1.y      = coord_t'(t1y);
        s.tank2.x      = coord_t'(t2x);
        s.tank2.y      = coord_t'(t2y);
        s.bullet.x     = coord_t'(bx);
        s.bullet.y     = coord_t'(by);
        s.heading      = heading_t'(head);
        s.bulletActive = bulletOn;
        s.halfSize     = coord_t'(half);
        return s;
    endfunction

    function automatic int randBelow(input int n);
        return int'({$random(seed)} % n);
    endfunction

    // ----------------------------------------
    // drive and compare helpers
    // ----------------------------------------

    task automatic checkOutputs(input string name, input scene_t s);
        rgb_t expPixel;
        logic expH;
        logic expV;
        expPixel = refColor(outCol, outRow, s);
        expH = !(outCol >= hSyncFirst && outCol < hSyncFirst + hSyncLen);
        expV = !(outRow >= vSyncFirst && outRow < vSyncFirst + vSyncLen);
        assert (pixel === expPixel)
        else
        begin
            $display("FAIL %s: pixel at (%0d,%0d) expected %h got %h",
                     name, outCol, outRow, expPixel, pixel);
            abortRun;
        end
        assert (hSync === expH)
        else
        begin
            $display("FAIL %s: hSync at (%0d,%0d) expected %b got %b",
                     name, outCol, outRow, expH, hSync);
            abortRun;
        end
        assert (vSync === expV)
        else
        begin
            $display("FAIL %s: vSync at (%0d,%0d) expected %b got %b",
                     name, outCol, outRow, expV, vSync);
            abortRun;
        end
    endtask

    // first output after a commit, the last one comes at the next (0,0)
    task automatic waitFrame;
        @(negedge clk);
        while (!(outValid && outCol == 1 && outRow == 0))
            @(negedge clk);
    endtask

    task automatic compareCycles(input string name, input scene_t s, input int count);
        for (int i = 0; i < count; i++)
        begin
            if (i > 0)
                @(negedge clk);
            checkOutputs(name, s);
        end
    endtask

    task automatic compareFrame(input string name, input scene_t s);
        waitFrame;
        compareCycles(name, s, frameLen);
    endtask

    // keep the strobe off the frame start cycle
    task automatic loadScene(input scene_t s);
        if (mCol == 0 && mRow == 0)
            @(negedge clk);
        load = 1'b1;
        update = s;
        @(negedge clk);
        load = 1'b0;
    endtask

    task automatic runScene(input string name, input scene_t s);
        loadScene(s);
        compareFrame(name, s);
    endtask

    // ----------------------------------------
    // directed tests
    // ----------------------------------------

    task automatic resetBehaviour;
        repeat (5)
        begin
            @(negedge clk);
            assert (pixel === blankColor)
            else
            begin
                $display("FAIL reset: pixel expected %h got %h", blankColor, pixel);
                abortRun;
            end
            assert (hSync === 1'b1 && vSync === 1'b1)
            else
            begin
                $display("FAIL reset: syncs expected 1/1 got %b/%b", hSync, vSync);
                abortRun;
            end
        end
        rstN = 1'b1;
    endtask

    // zero scene from reset, syncs and blanking checked on every cycle
    task automatic syncTiming;
        compareFrame("sync", '0);
    endtask

    // tank boxes overlap around x 11..13, y 8..11
    task automatic unrotatedScene;
        runScene("unrotated", makeScene(10, 8, 14, 11, 25, 20, 0, 1'b0, 3));
    endtask

    task automatic rotationHeadings;
        int headings [4];
        scene_t s;
        headings[0] = 2;
        headings[1] = 4;
        headings[2] = 9;
        headings[3] = randBelow(16);
        foreach (headings[i])
        begin
            s = makeScene(randBelow(hVisible), randBelow(vVisible),
                          randBelow(hVisible), randBelow(vVisible),
                          randBelow(hVisible), randBelow(vVisible),
                          headings[i], 1'b1, 1 + randBelow(5));
            runScene($sformatf("rotation h%0d", headings[i]), s);
        end
    endtask

    // tank 1 covers the bullet's top left corner
    task automatic bulletDrawing;
        runScene("bullet off", makeScene(22, 14, 6, 20, 24, 16, 0, 1'b0, 2));
        runScene("bullet on", makeScene(22, 14, 6, 20, 24, 16, 0, 1'b1, 2));
    endtask

    task automatic frameCommit;
        scene_t sceneA;
        scene_t sceneB;
        scene_t sceneC;
        sceneA = makeScene(5, 5, 20, 15, 28, 3, 3, 1'b1, 2);
        sceneB = makeScene(25, 18, 8, 9, 15, 12, 6, 1'b1, 3);
        sceneC = makeScene(16, 4, 26, 20, 4, 19, 12, 1'b1, 4);
        runScene("commit A", sceneA);
        // load in the middle, rest of the frame keeps scene A
        compareCycles("commit mid", sceneA, 500);
        loadScene(sceneB);
        compareCycles("commit mid", sceneA, frameLen - (outRow * lineLen + outCol) + 1);
        compareFrame("commit B", sceneB);
        // run up to the cycle whose counter state is (0,0)
        compareCycles("commit B", sceneB, frameLen);
        while (!(mCol == 0 && mRow == 0))
            @(negedge clk);
        load = 1'b1;
        update = sceneC;
        @(negedge clk);
        load = 1'b0;
        // strobe on frame start only reaches pending
        compareFrame("commit same cycle", sceneB);
        compareFrame("commit C", sceneC);
    endtask

    initial
    begin
        rstN = 1'b0;
        load = 1'b0;
        update = '0;
        resetBehaviour();
        syncTiming();
        unrotatedScene();
        rotationHeadings();
        bulletDrawing();
        frameCommit();
        $display("Everything OK");
        $finish;
    end

endmodule

//--- files.f
design/arenaPkg.sv
design/vgaTiming.sv
design/sinCosRom.sv
design/rotatePoint.sv
design/sceneRegs.sv
design/colorMapper.sv
design/arenaTop.sv
verification/tbArena.sv

//--- run.sh
#!/bin/sh
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tbArena -f files.f \
    -o simArena > build.log 2>&1 \
    && ./obj_dir/simArena > sim.log 2>&1
grep -q "Everything OK" sim.log 2>/dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }
